/* src/piPkg.sv */
package piPkg;

  // Bit 0 is the most significant bit
  typedef logic [0:17] piWord;

  typedef logic [1:7] piMask;   // One bit per level
  typedef logic [2:0] piLevel;  // 1 highest, 7 lowest, 0 none

  typedef enum logic [1:0] {
    seqIdle,
    seqRequest,
    seqDone
  } piSeqState;

  localparam int piTimeoutCycles = 8;

  typedef logic [$clog2(piTimeoutCycles + 1)-1:0] piWaitCount;

  // Lowest-numbered set bit or 0 for an empty mask
  function automatic piLevel firstLevel(piMask m);
    piLevel lvl;
    lvl = '0;
    for (int n = 7; n >= 1; n--) begin
      if (m[n]) lvl = piLevel'(n);
    end
    return lvl;
  endfunction

  function automatic piMask levelMask(piLevel lvl);
    piMask m;
    m = '0;
    for (int n = 1; n <= 7; n++) begin
      if (lvl == piLevel'(n)) m[n] = 1'b1;
    end
    return m;
  endfunction

endpackage

/* src/piCycleIf.sv */
interface piCycleIf;
  import piPkg::*;

  logic   reqValid;   // Winner outranks every held level
  piLevel reqLevel;
  logic   cycleDone;  // One cycle, at the end of a bus cycle
  piLevel doneLevel;

  modport arb (
    output reqValid,
    output reqLevel
  );

  modport hold (
    input cycleDone,
    input doneLevel
  );

  modport seq (
    input  reqValid,
    input  reqLevel,
    output cycleDone,
    output doneLevel
  );

endinterface

/* src/piLevelRegs.sv */
module piLevelRegs (
  input  logic          clk,
  input  logic          RESET,
  input  logic          conoPi,
  input  logic          conoApr,
  input  logic          piDismiss,
  input  piPkg::piWord  iobData,
  output piPkg::piMask  on,
  output piPkg::piMask  gen,
  output piPkg::piMask  held,
  output logic          active,
  output piPkg::piLevel aprPia,
  piCycleIf.hold        cyc
);
  import piPkg::*;

  piMask sel;
  logic  sysClr;
  logic  genClr;
  logic  genSet;
  logic  onSet;
  logic  onClr;
  logic  actClr;
  logic  actSet;
  piMask dismissMask;
  piMask doneMask;

  // CONO PI decode
  always_comb begin
    sel    = iobData[11:17];
    sysClr = conoPi & iobData[5];
    genClr = conoPi & iobData[4];
    genSet = conoPi & iobData[6];
    onSet  = conoPi & iobData[7];
    onClr  = conoPi & iobData[8];
    actClr = conoPi & iobData[9];
    actSet = conoPi & iobData[10];
  end

  // Dismiss drops the highest-priority level in progress
  assign dismissMask = {7{piDismiss}} & levelMask(firstLevel(held));
  assign doneMask    = {7{cyc.cycleDone}} & levelMask(cyc.doneLevel);

  always_ff @(posedge clk) begin
    if (RESET || sysClr) begin
      on     <= '0;
      gen    <= '0;
      held   <= '0;
      active <= 1'b0;
    end else begin
      // Clear wins over set
      on   <= (on | ({7{onSet}} & sel)) & ~({7{onClr}} & sel);
      gen  <= (gen | ({7{genSet}} & sel)) & ~({7{genClr}} & sel);
      held <= (held & ~dismissMask) | doneMask;
      if (actClr) begin
        active <= 1'b0;
      end else if (actSet) begin
        active <= 1'b1;
      end
    end
  end

  // APR PIA from CONO APR bits 15-17
  always_ff @(posedge clk) begin
    if (RESET) begin
      aprPia <= '0;
    end else if (conoApr) begin
      aprPia <= iobData[15:17];
    end
  end

endmodule

/* src/piPriority.sv */
module piPriority (
  input  piPkg::piMask  on,
  input  piPkg::piMask  gen,
  input  piPkg::piMask  held,
  input  logic          active,
  input  piPkg::piMask  ioReq,
  input  logic          aprInterrupt,
  input  piPkg::piLevel aprPia,
  piCycleIf.arb         cyc
);
  import piPkg::*;

  piMask  aprMask;
  piMask  reqMask;
  piLevel winLevel;
  piLevel heldLevel;
  logic   outranks;

  // APR interrupt lands on the level in its PIA
  assign aprMask = {7{aprInterrupt}} & levelMask(aprPia);

  // Device and APR requests need the level on and GEN needs only ACTIVE
  assign reqMask = {7{active}} & (gen | (on & (ioReq | aprMask)));

  assign winLevel  = firstLevel(reqMask);
  assign heldLevel = firstLevel(held);

  // Equal or lower levels wait for the dismiss
  always_comb begin
    if (heldLevel == 3'd0) begin
      outranks = 1'b1;
    end else begin
      outranks = winLevel < heldLevel;
    end
  end

  assign cyc.reqLevel = winLevel;
  assign cyc.reqValid = (winLevel != 3'd0) && outranks;

endmodule

/* src/piCycleSeq.sv */
module piCycleSeq (
  input  logic          clk,
  input  logic          RESET,
  input  logic          busXfer,
  input  piPkg::piWord  busData,
  output logic          busReq,
  output piPkg::piLevel busLevel,
  output logic          piCycle,
  output piPkg::piWord  piVector,
  output logic          piTimeout,
  piCycleIf.seq         cyc
);
  import piPkg::*;

  piSeqState  state;
  piWaitCount waitCount;
  logic       timedOut;

  assign timedOut = waitCount == piWaitCount'(piTimeoutCycles);

  always_ff @(posedge clk) begin
    if (RESET) begin
      state     <= seqIdle;
      piTimeout <= 1'b0;
    end else begin
      piTimeout <= 1'b0;
      case (state)
        seqIdle: begin
          if (cyc.reqValid) state <= seqRequest;
        end
        seqRequest: begin
          if (busXfer) begin
            state <= seqDone;
          end else if (timedOut) begin
            state     <= seqDone;
            piTimeout <= 1'b1;  // Lines up with piCycle
          end
        end
        default: state <= seqIdle;  // seqDone is a single cycle
      endcase
    end
  end

  // Granted level, wait count and vector
  always_ff @(posedge clk) begin
    case (state)
      seqIdle: begin
        waitCount <= '0;
        if (cyc.reqValid) busLevel <= cyc.reqLevel;
      end
      seqRequest: begin
        waitCount <= waitCount + 1'b1;
        if (busXfer) begin
          piVector <= busData;
        end else if (timedOut) begin
          piVector <= '0;  // No device answered
        end
      end
      default: ;
    endcase
  end

  assign busReq  = state == seqRequest;
  assign piCycle = state == seqDone;

  assign cyc.cycleDone = piCycle;
  assign cyc.doneLevel = busLevel;

endmodule

/* src/piTop.sv */
module piTop (
  input  logic          clk,
  input  logic          RESET,
  input  logic          conoPi,
  input  logic          conoApr,
  input  logic          piDismiss,
  input  piPkg::piWord  iobData,
  input  piPkg::piMask  ioReq,
  input  logic          aprInterrupt,
  input  logic          busXfer,
  input  piPkg::piWord  busData,
  output logic          busReq,
  output piPkg::piLevel busLevel,
  output logic          piCycle,
  output piPkg::piLevel piCycleLevel,
  output piPkg::piWord  piVector,
  output logic          piTimeout,
  output piPkg::piWord  piStatus,
  output piPkg::piLevel aprPia
);
  import piPkg::*;

  piMask on;
  piMask gen;
  piMask held;
  logic  active;

  piCycleIf cyc ();

  piLevelRegs regs_i (
    .clk       (clk),
    .RESET     (RESET),
    .conoPi    (conoPi),
    .conoApr   (conoApr),
    .piDismiss (piDismiss),
    .iobData   (iobData),
    .on        (on),
    .gen       (gen),
    .held      (held),
    .active    (active),
    .aprPia    (aprPia),
    .cyc       (cyc.hold)
  );

  piPriority prio_i (
    .on           (on),
    .gen          (gen),
    .held         (held),
    .active       (active),
    .ioReq        (ioReq),
    .aprInterrupt (aprInterrupt),
    .aprPia       (aprPia),
    .cyc          (cyc.arb)
  );

  piCycleSeq seq_i (
    .clk       (clk),
    .RESET     (RESET),
    .busXfer   (busXfer),
    .busData   (busData),
    .busReq    (busReq),
    .busLevel  (busLevel),
    .piCycle   (piCycle),
    .piVector  (piVector),
    .piTimeout (piTimeout),
    .cyc       (cyc.seq)
  );

  // ON in 3-9, GEN in 10-16, ACTIVE in 17
  assign piStatus     = {3'b000, on, gen, active};
  assign piCycleLevel = cyc.doneLevel;

endmodule

/* sim/piCycleSeq_asserts.sv */
module piCycleSeqAsserts (
  input logic          clk,
  input logic          RESET,
  input logic          busReq,
  input piPkg::piLevel busLevel,
  input logic          piCycle
);
  int failCount = 0;

  reqNotDone: assert property (@(posedge clk) disable iff (RESET) !(busReq && piCycle))
  else begin
    $error("busReq and piCycle high together");
    failCount++;
  end

  cycleOnePulse: assert property (@(posedge clk) disable iff (RESET) piCycle |=> !piCycle)
  else begin
    $error("piCycle longer than one cycle");
    failCount++;
  end

  levelStable: assert property (@(posedge clk) disable iff (RESET)
    busReq && $past(busReq) |-> busLevel == $past(busLevel))
  else begin
    $error("busLevel changed during busReq");
    failCount++;
  end

endmodule

bind piCycleSeq piCycleSeqAsserts asserts_i (
  .clk(clk), .RESET(RESET), .busReq(busReq), .busLevel(busLevel), .piCycle(piCycle)
);

/* sim/piTb.sv */
module piTb;
  import piPkg::*;

  localparam int clkPeriod  = 20;
  localparam int numCono    = 24;
  localparam int testCycles = 4 + (numCono * 2 + 40) + 30 + 60 + (piTimeoutCycles + 30) + 80;

  logic   clk;
  logic   RESET;
  logic   conoPi;
  logic   conoApr;
  logic   piDismiss;
  piWord  iobData;
  piMask  ioReq;
  logic   aprInterrupt;
  logic   busXfer;
  piWord  busData;
  logic   busReq;
  piLevel busLevel;
  logic   piCycle;
  piLevel piCycleLevel;
  piWord  piVector;
  logic   piTimeout;
  piWord  piStatus;
  piLevel aprPia;
  int     errors;

  piTop dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic checkWord(string name, piWord expected, piWord actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkLevel(string name, piLevel expected, piLevel actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkMask(string name, piMask expected, piMask actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkBit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, got %h", name, expected, actual);
      errors++;
    end
  endtask

  function automatic piWord bitWord(int b);
    piWord w;
    w = '0;
    w[b] = 1'b1;
    return w;
  endfunction

  // Level select is bits 11-17
  function automatic piWord levelWord(piLevel lvl, piWord ctl);
    piWord w;
    w = ctl;
    w[10 + int'(lvl)] = 1'b1;
    return w;
  endfunction

  task automatic sendCono(piWord word);
    @(posedge clk);
    iobData <= word;
    conoPi  <= 1'b1;
    @(posedge clk);
    conoPi  <= 1'b0;
  endtask

  task automatic sendApr(piLevel lvl);
    @(posedge clk);
    iobData <= piWord'(lvl);  // Lands in bits 15-17
    conoApr <= 1'b1;
    @(posedge clk);
    conoApr <= 1'b0;
  endtask

  task automatic dismiss();
    @(posedge clk);
    piDismiss <= 1'b1;
    @(posedge clk);
    piDismiss <= 1'b0;
  endtask

  // Bus request one cycle after reqValid
  task automatic expectGrant(piLevel lvl);
    @(posedge clk);
    @(negedge clk);
    checkBit("busReq", 1'b1, busReq);
    checkLevel("busLevel", lvl, busLevel);
  endtask

  task automatic transfer(piLevel lvl);
    piWord vec;
    vec = piWord'($urandom);
    @(posedge clk);
    busXfer      <= 1'b1;
    busData      <= vec;
    ioReq[lvl]   <= 1'b0;
    aprInterrupt <= 1'b0;
    @(posedge clk);
    busXfer <= 1'b0;
    @(negedge clk);
    checkBit("piCycle", 1'b1, piCycle);
    checkBit("piTimeout", 1'b0, piTimeout);
    checkLevel("piCycleLevel", lvl, piCycleLevel);
    checkWord("piVector", vec, piVector);
  endtask

  // A second system clear drops the held bit of any cycle still in flight
  task automatic clearAll();
    int n;
    n = 0;
    sendCono(bitWord(5));
    @(negedge clk);
    while ((busReq || piCycle) && n < 2 * piTimeoutCycles) begin
      @(negedge clk);
      n++;
    end
    if (busReq || piCycle) begin
      $display("Bus cycle still running long after a system clear");
      errors++;
    end
    sendCono(bitWord(5));
  endtask

  task automatic conoControl();
    piWord w;
    piMask sel;
    piMask onModel;
    piMask genModel;
    logic  actModel;
    onModel  = '0;
    genModel = '0;
    actModel = 1'b0;
    for (int i = 0; i < numCono; i++) begin
      w = piWord'($urandom);
      if ($urandom_range(3, 0) != 0) w[5] = 1'b0;  // Keep system clears rare
      sel = w[11:17];
      if (w[5]) begin
        onModel  = '0;
        genModel = '0;
        actModel = 1'b0;
      end else begin
        for (int n = 1; n <= 7; n++) begin
          if (sel[n] && w[8]) begin
            onModel[n] = 1'b0;
          end else if (sel[n] && w[7]) begin
            onModel[n] = 1'b1;
          end
          if (sel[n] && w[4]) begin
            genModel[n] = 1'b0;
          end else if (sel[n] && w[6]) begin
            genModel[n] = 1'b1;
          end
        end
        if (w[9]) begin
          actModel = 1'b0;
        end else if (w[10]) begin
          actModel = 1'b1;
        end
      end
      sendCono(w);
      @(negedge clk);
      checkMask("piStatus.on", onModel, piStatus[3:9]);
      checkMask("piStatus.gen", genModel, piStatus[10:16]);
      checkBit("piStatus.active", actModel, piStatus[17]);
    end
    clearAll();
  endtask

  task automatic deviceInterrupt();
    piLevel lvl;
    lvl = piLevel'($urandom_range(7, 1));
    sendCono(levelWord(lvl, bitWord(10) | bitWord(7)));
    @(posedge clk);
    ioReq[lvl] <= 1'b1;
    expectGrant(lvl);
    transfer(lvl);
    dismiss();
  endtask

  task automatic priorityHold();
    piLevel hi;
    piLevel lo;
    hi = piLevel'($urandom_range(6, 1));
    lo = piLevel'($urandom_range(7, int'(hi) + 1));
    sendCono(levelWord(hi, levelWord(lo, bitWord(7))));
    @(posedge clk);
    ioReq[hi] <= 1'b1;
    ioReq[lo] <= 1'b1;
    expectGrant(hi);
    transfer(hi);
    repeat (4) begin
      @(negedge clk);
      checkBit("busReq", 1'b0, busReq);  // Blocked by the held level
    end
    dismiss();
    expectGrant(lo);
    transfer(lo);
    dismiss();
  endtask

  task automatic timeoutFallback();
    piLevel lvl;
    lvl = piLevel'($urandom_range(7, 1));
    sendCono(levelWord(lvl, bitWord(7)));
    @(posedge clk);
    ioReq[lvl] <= 1'b1;
    expectGrant(lvl);
    repeat (piTimeoutCycles) begin
      @(posedge clk);
      ioReq[lvl] <= 1'b0;
      @(negedge clk);
      checkBit("piCycle", 1'b0, piCycle);
    end
    @(posedge clk);
    @(negedge clk);
    checkBit("piCycle", 1'b1, piCycle);
    checkBit("piTimeout", 1'b1, piTimeout);
    checkLevel("piCycleLevel", lvl, piCycleLevel);
    checkWord("piVector", '0, piVector);
    dismiss();
  endtask

  task automatic aprAndGenerate();
    piLevel apr;
    piLevel genLvl;
    apr    = piLevel'($urandom_range(7, 1));
    genLvl = piLevel'($urandom_range(6, 1));
    sendApr(apr);
    @(negedge clk);
    checkLevel("aprPia", apr, aprPia);
    sendCono(levelWord(apr, bitWord(7)));
    @(posedge clk);
    aprInterrupt <= 1'b1;
    expectGrant(apr);
    transfer(apr);
    dismiss();
    sendCono(levelWord(genLvl, bitWord(6)));
    expectGrant(genLvl);
    transfer(genLvl);
    sendCono(bitWord(5));
    repeat (3) begin
      @(negedge clk);
      checkWord("piStatus", '0, piStatus);
      checkBit("busReq", 1'b0, busReq);
    end
    // Level 7 only gets through once the held level is gone
    sendCono(levelWord(3'd7, bitWord(10) | bitWord(6)));
    expectGrant(3'd7);
    transfer(3'd7);
    clearAll();
  endtask

  initial begin
    void'($urandom(13630));
    errors       = 0;
    RESET        = 1'b1;
    conoPi       = 1'b0;
    conoApr      = 1'b0;
    piDismiss    = 1'b0;
    iobData      = '0;
    ioReq        = '0;
    aprInterrupt = 1'b0;
    busXfer      = 1'b0;
    busData      = '0;
    repeat (4) @(posedge clk);
    RESET <= 1'b0;
    conoControl();
    deviceInterrupt();
    priorityHold();
    timeoutFallback();
    aprAndGenerate();
    $display("Errors: %0d checks, %0d assertions", errors, dut_i.seq_i.asserts_i.failCount);
    if (errors == 0 && dut_i.seq_i.asserts_i.failCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(testCycles * 2 * clkPeriod);
    $display("Run timed out after %0d cycles", testCycles * 2);
    $display("Verification failed");
    $finish;
  end

endmodule

/* vlog.f */
src/piPkg.sv
src/piCycleIf.sv
src/piLevelRegs.sv
src/piPriority.sv
src/piCycleSeq.sv
src/piTop.sv
sim/piCycleSeq_asserts.sv
sim/piTb.sv

/* Makefile */
TOP       ?= piTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+100

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	$(SIM) $(RUNFLAGS) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
